// File: src.f
hw/soc_bus_pkg.sv
hw/dev_map_pkg.sv
hw/dev_bus_decode.sv
hw/sys_timer.sv
hw/kbd_queue.sv
hw/io_regs.sv
hw/dev_block_top.sv
test/dev_block_chk.sv
test/dev_block_tb.sv

// File: run.sh
#!/bin/sh
# build and run the device block testbench with verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -Wno-fatal -f src.f \
    --top-module dev_block_tb -o dev_block_sim
out=$(./obj_dir/dev_block_sim)
echo "$out"
echo "$out" | grep -qx "Verification passed"

// File: test/dev_block_tb.sv
/*
  random bus traffic against a model of the display, sd pins and keyboard queue
  DUT built with a 20-cycle timer period and a 4-entry keyboard queue
*/
`timescale 1ns/1ps

module dev_block_tb;

    localparam int PERIOD = 20;
    localparam logic [31:0] A_SYS  = 32'h2000_0000;
    localparam logic [31:0] A_DISP = 32'h2000_1000;
    localparam logic [31:0] A_KBD  = 32'h2000_5000;
    localparam logic [31:0] A_SD   = 32'h2000_6000;

    logic clk, reset_i, sel_i, we_i, eoi_i, kbd_strobe_i, sd_miso_i;
    logic [31:0] addr_i, wdata_i, rdata_o;
    logic [7:0] kbd_code_i, display_o;
    logic ack_o, irq_o, sd_csn_o, sd_sclk_o, sd_mosi_o;

    int errors = 0;
    logic [31:0] rng = 32'had8aa9de;
    // keyboard model holds the pending codes and the last dequeued one
    logic [7:0] key_q [$];
    logic [7:0] last_code;
    logic code_valid = 1'b0;

    dev_block_top #(.CLK_HZ(1000), .TICK_HZ(50), .KBD_DEPTH_LOG2(2)) UUT (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic logic [31:0] next_random();
        rng ^= rng << 13;
        rng ^= rng >> 17;
        rng ^= rng << 5;
        return rng;
    endfunction

    task automatic check_value(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
        assert (got === exp) else begin
            errors++;
            $display("[FAIL] %0t: %s got %h expected %h", $time, what, got, exp);
        end
    endtask

    // one bus cycle as the cpu runs it
    task automatic bus_xfer(input logic wr, input logic [31:0] addr, input logic [31:0] data,
                            input int max_cycles, output logic [31:0] rdata,
                            output logic got_ack);
        int n;
        n = 0;
        got_ack = 1'b0;
        rdata = '0;
        @(negedge clk);
        sel_i = 1'b1;
        we_i = wr;
        addr_i = addr;
        wdata_i = data;
        while (!got_ack && n < max_cycles) begin
            @(negedge clk);
            n++;
            if (ack_o) begin
                got_ack = 1'b1;
                rdata = rdata_o;
            end
        end
        // sel stays up through the cycle after ack is seen
        if (got_ack)
            @(negedge clk);
        sel_i = 1'b0;
        we_i = 1'b0;
    endtask

    task automatic write_reg(input logic [31:0] addr, input logic [31:0] data);
        logic [31:0] rd;
        logic ok;
        bus_xfer(1'b1, addr, data, 8, rd, ok);
        assert (ok) else begin
            errors++;
            $display("no ack for the write to %h within 8 cycles at %0t", addr, $time);
        end
    endtask

    task automatic read_reg(input logic [31:0] addr, output logic [31:0] data);
        logic ok;
        bus_xfer(1'b0, addr, 32'h0, 8, data, ok);
        assert (ok) else begin
            errors++;
            $display("no ack for the read of %h within 8 cycles at %0t", addr, $time);
        end
    endtask

    // enqueue lands one cycle after the strobe, so two edges are enough
    task automatic send_key(input logic [7:0] code);
        @(negedge clk);
        kbd_code_i = code;
        kbd_strobe_i = 1'b1;
        @(negedge clk);
        kbd_strobe_i = 1'b0;
        @(negedge clk);
        if (key_q.size() < 4)
            key_q.push_back(code);
    endtask

    task automatic wait_irq(input logic level, input int max_cycles, input string what);
        int n;
        n = 0;
        while (irq_o !== level && n < max_cycles) begin
            @(negedge clk);
            n++;
        end
        assert (irq_o === level) else begin
            errors++;
            $display("%s within %0d cycles at %0t", what, max_cycles, $time);
        end
    endtask

    initial begin
        logic [31:0] r;
        logic [31:0] d;
        logic ok;
        int op;
        reset_i = 1'b1;
        sel_i = 1'b0;
        we_i = 1'b0;
        addr_i = '0;
        wdata_i = '0;
        eoi_i = 1'b1;
        kbd_code_i = '0;
        kbd_strobe_i = 1'b0;
        sd_miso_i = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        reset_i = 1'b0;

        for (int i = 0; i < 200; i++) begin
            d = next_random();
            op = int'(next_random() % 5);
            case (op)
                0: begin
                    write_reg(A_DISP, d);
                    read_reg(A_DISP, r);
                    check_value("display readback", r, {24'h0, d[7:0]});
                    check_value("display pins", {24'h0, display_o}, {24'h0, d[7:0]});
                end
                1: begin
                    write_reg(A_SD, d);
                    check_value("sd pins", {29'h0, sd_sclk_o, sd_csn_o, sd_mosi_o},
                                {29'h0, d[2], ~d[1], d[0]});
                    sd_miso_i = d[7];
                    read_reg(A_SD, r);
                    check_value("sd miso readback", r, {31'h0, d[7]});
                end
                3: begin
                    read_reg(A_KBD, r);
                    check_value("kbd status", r, {31'h0, key_q.size() != 0});
                    write_reg(A_KBD, d);
                    if (key_q.size() != 0) begin
                        last_code = key_q.pop_front();
                        code_valid = 1'b1;
                    end
                    read_reg(A_KBD + 32'h4, r);
                    if (code_valid)
                        check_value("kbd code", r, {24'h0, last_code});
                end
                default: send_key(d[7:0]);
            endcase
        end

        // region decode
        bus_xfer(1'b0, 32'h3000_0000, 32'h0, 8, r, ok);
        assert (!ok) else begin
            errors++;
            $display("read outside the device region was acknowledged at %0t", $time);
        end
        read_reg(32'h2000_3000, r);
        check_value("unmapped offset", r, 32'h0);

        // timer interrupt and the eoi handshake
        write_reg(A_SYS, 32'h1);
        read_reg(A_SYS, r);
        check_value("timer enable", r, 32'h1);
        wait_irq(1'b1, PERIOD + 10, "irq_o did not rise after the enable");
        eoi_i = 1'b0;
        @(negedge clk);
        @(negedge clk);
        eoi_i = 1'b1;
        wait_irq(1'b0, 8, "irq_o did not clear after the eoi handshake");
        write_reg(A_SYS, 32'h0);
        read_reg(A_SYS, r);
        check_value("timer disable", r, 32'h0);
        for (int i = 0; i < 2 * PERIOD + 5; i++) begin
            @(negedge clk);
            check_value("irq with timer disabled", {31'h0, irq_o}, 32'h0);
        end

        $display("errors: %0d", errors);
        if (errors == 0)
            $display("Verification passed");
        else
            $display("Verification failed");
        $finish;
    end

endmodule

// File: test/dev_block_chk.sv
/*
  bus, interrupt and sd reset properties, bound into dev_block_top
*/
`timescale 1ns/1ps

module dev_block_chk (
    input wire logic clk,
    input wire logic reset_i,
    input wire logic sel_i,
    input wire logic ack_i,
    input wire logic irq_i,
    input wire logic tmr_ena_i,
    input wire logic sd_csn_i
);

    // ack is registered from sel
    ack_follows_sel: assert property (@(posedge clk) disable iff (reset_i)
        ack_i |-> $past(sel_i))
        else $error("ack_o high without sel_i in the previous cycle");

    irq_quiet_when_off: assert property (@(posedge clk) disable iff (reset_i)
        (!tmr_ena_i && !irq_i) |=> !irq_i)
        else $error("irq_o rose while the timer was disabled");

    // card deselected once reset has been seen
    sd_deselected_after_reset: assert property (@(posedge clk)
        reset_i |=> sd_csn_i)
        else $error("sd_csn_o low in the cycle after reset");

endmodule

bind dev_block_top dev_block_chk u_chk (
    .clk       (clk),
    .reset_i   (reset_i),
    .sel_i     (sel_i),
    .ack_i     (ack_o),
    .irq_i     (irq_o),
    .tmr_ena_i (tmr_ena),
    .sd_csn_i  (sd_csn_o)
);

// File: hw/dev_block_top.sv
/*
  device block of the soc, device region only; timer is the single irq source
  eoi_i is a level from the cpu, high when ready for an interrupt
*/
`timescale 1ns/1ps

module dev_block_top #(
    parameter int CLK_HZ         = 12_000_000,
    parameter int TICK_HZ        = 1000,
    parameter int KBD_DEPTH_LOG2 = 5
) (
    input  wire logic          clk,
    input  wire logic          reset_i,
    input  wire logic          sel_i,
    input  soc_bus_pkg::addr_t addr_i,
    input  wire logic          we_i,
    input  soc_bus_pkg::data_t wdata_i,
    input  wire logic          eoi_i,
    input  soc_bus_pkg::byte_t kbd_code_i,
    input  wire logic          kbd_strobe_i,
    input  wire logic          sd_miso_i,
    output logic               ack_o,
    output soc_bus_pkg::data_t rdata_o,
    output logic               irq_o,
    output soc_bus_pkg::byte_t display_o,
    output logic               sd_csn_o,
    output logic               sd_sclk_o,
    output logic               sd_mosi_o
);

    logic               tmr_ena;
    logic               tmr_ena_we;
    logic               disp_we;
    logic               sd_we;
    logic               kbd_deq_req;
    logic               kbd_nonempty;
    soc_bus_pkg::byte_t kbd_code;

    dev_bus_decode u_decode (
        .clk            (clk),
        .reset_i        (reset_i),
        .sel_i          (sel_i),
        .addr_i         (addr_i),
        .we_i           (we_i),
        .wdata_i        (wdata_i),
        .tmr_ena_i      (tmr_ena),
        .disp_i         (display_o),
        .kbd_nonempty_i (kbd_nonempty),
        .kbd_code_i     (kbd_code),
        .sd_miso_i      (sd_miso_i),
        .ack_o          (ack_o),
        .rdata_o        (rdata_o),
        .tmr_ena_we_o   (tmr_ena_we),
        .disp_we_o      (disp_we),
        .sd_we_o        (sd_we),
        .kbd_deq_req_o  (kbd_deq_req)
    );

    sys_timer #(
        .CLK_HZ  (CLK_HZ),
        .TICK_HZ (TICK_HZ)
    ) u_timer (
        .clk         (clk),
        .reset_i     (reset_i),
        .ena_we_i    (tmr_ena_we),
        .wdata_bit_i (wdata_i[0]),
        .eoi_i       (eoi_i),
        .ena_o       (tmr_ena),
        .irq_o       (irq_o)
    );

    kbd_queue #(
        .KBD_DEPTH_LOG2 (KBD_DEPTH_LOG2)
    ) u_kbd (
        .clk        (clk),
        .reset_i    (reset_i),
        .code_i     (kbd_code_i),
        .strobe_i   (kbd_strobe_i),
        .deq_req_i  (kbd_deq_req),
        .nonempty_o (kbd_nonempty),
        .code_o     (kbd_code)
    );

    io_regs u_io (
        .clk       (clk),
        .reset_i   (reset_i),
        .disp_we_i (disp_we),
        .sd_we_i   (sd_we),
        .wdata_i   (wdata_i),
        .display_o (display_o),
        .sd_csn_o  (sd_csn_o),
        .sd_sclk_o (sd_sclk_o),
        .sd_mosi_o (sd_mosi_o)
    );

endmodule

// File: hw/io_regs.sv
/*
  display byte and bit-banged sd pins, updated at the write edge
  sd chip select is active low on the pin, active high in the written word
*/
`timescale 1ns/1ps

module io_regs (
    input  wire logic          clk,
    input  wire logic          reset_i,
    input  wire logic          disp_we_i,
    input  wire logic          sd_we_i,
    input  soc_bus_pkg::data_t wdata_i,
    output soc_bus_pkg::byte_t display_o,
    output logic               sd_csn_o,
    output logic               sd_sclk_o,
    output logic               sd_mosi_o
);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            display_o <= '0;
        end else if (disp_we_i) begin
            display_o <= wdata_i[soc_bus_pkg::BYTE_W-1:0];
        end
    end

    // card deselected, clock idle low
    always_ff @(posedge clk) begin
        if (reset_i) begin
            sd_csn_o  <= 1'b1;
            sd_sclk_o <= 1'b0;
            sd_mosi_o <= 1'b0;
        end else if (sd_we_i) begin
            sd_csn_o  <= ~wdata_i[dev_map_pkg::SD_BIT_CS];
            sd_sclk_o <= wdata_i[dev_map_pkg::SD_BIT_SCLK];
            sd_mosi_o <= wdata_i[dev_map_pkg::SD_BIT_MOSI];
        end
    end

endmodule

// File: hw/kbd_queue.sv
/*
  strobe enqueues one cycle later, dropped when the queue is full
  code_o holds the dequeued head from two cycles after the dequeue request
*/
`timescale 1ns/1ps

module kbd_queue #(
    parameter int KBD_DEPTH_LOG2 = 5
) (
    input  wire logic          clk,
    input  wire logic          reset_i,
    input  soc_bus_pkg::byte_t code_i,
    input  wire logic          strobe_i,
    input  wire logic          deq_req_i,
    output logic               nonempty_o,
    output soc_bus_pkg::byte_t code_o
);

    localparam int DEPTH = 1 << KBD_DEPTH_LOG2;

    soc_bus_pkg::byte_t mem [DEPTH];

    logic [KBD_DEPTH_LOG2-1:0] wr_ptr;
    logic [KBD_DEPTH_LOG2-1:0] rd_ptr;
    logic [KBD_DEPTH_LOG2:0]   count;
    logic                      enq;
    logic                      deq;
    logic                      full;
    soc_bus_pkg::byte_t        enq_data;

    assign nonempty_o = (count != '0);

    // a pending enqueue already takes a slot
    assign full = (int'(count) + int'(enq)) >= DEPTH;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            enq    <= 1'b0;
            deq    <= 1'b0;
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            enq <= strobe_i && !full;
            deq <= deq_req_i && nonempty_o;
            if (enq)
                wr_ptr <= wr_ptr + 1'b1;
            if (deq)
                rd_ptr <= rd_ptr + 1'b1;
            case ({enq, deq})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // storage and data path
    always_ff @(posedge clk) begin
        enq_data <= code_i;
        if (enq)
            mem[wr_ptr] <= enq_data;
        if (deq)
            code_o <= mem[rd_ptr];
    end

endmodule

// File: hw/sys_timer.sv
/*
  expiry every CLK_HZ/TICK_HZ cycles from reset; CLK_HZ must be a multiple of TICK_HZ
  an expiry while disabled, waiting or with eoi low is lost
*/
`timescale 1ns/1ps

module sys_timer #(
    parameter int CLK_HZ  = 12_000_000,
    parameter int TICK_HZ = 1000
) (
    input  wire logic clk,
    input  wire logic reset_i,
    input  wire logic ena_we_i,
    input  wire logic wdata_bit_i,
    input  wire logic eoi_i,
    output logic      ena_o,
    output logic      irq_o
);

    localparam int PERIOD = CLK_HZ / TICK_HZ;
    localparam int CNT_W  = (PERIOD > 1) ? $clog2(PERIOD) : 1;
    localparam logic [CNT_W-1:0] RELOAD = CNT_W'(PERIOD - 1);

    logic [CNT_W-1:0] count;
    logic             waiting;
    logic             expiry;

    assign expiry = (count == '0);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            count   <= RELOAD;
            ena_o   <= 1'b0;
            irq_o   <= 1'b0;
            waiting <= 1'b0;
        end else begin
            if (ena_we_i)
                ena_o <= wdata_bit_i;

            // eoi low acknowledges the request, eoi high again releases it
            if (waiting) begin
                if (!eoi_i)
                    waiting <= 1'b0;
            end else if (irq_o && eoi_i) begin
                irq_o <= 1'b0;
            end

            if (expiry) begin
                count <= RELOAD;
                if (ena_o && !waiting && eoi_i) begin
                    irq_o   <= 1'b1;
                    waiting <= 1'b1;
                end
            end else begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

// File: hw/dev_bus_decode.sv
/*
  master holds sel/addr/we/wdata until ack; writes act on the first cycle only
  addresses outside the device region are never acknowledged
*/
`timescale 1ns/1ps

module dev_bus_decode (
    input  wire logic               clk,
    input  wire logic               reset_i,
    input  wire logic               sel_i,
    input  soc_bus_pkg::addr_t      addr_i,
    input  wire logic               we_i,
    input  soc_bus_pkg::data_t      wdata_i,
    input  wire logic               tmr_ena_i,
    input  soc_bus_pkg::byte_t      disp_i,
    input  wire logic               kbd_nonempty_i,
    input  soc_bus_pkg::byte_t      kbd_code_i,
    input  wire logic               sd_miso_i,
    output logic                    ack_o,
    output soc_bus_pkg::data_t      rdata_o,
    output logic                    tmr_ena_we_o,
    output logic                    disp_we_o,
    output logic                    sd_we_o,
    output logic                    kbd_deq_req_o
);

    logic        region_hit;
    logic [3:0]  page;
    logic [11:0] ofs;
    logic        wr_first;

    assign region_hit = (addr_i[31:28] == dev_map_pkg::REGION_DEV);
    assign page       = addr_i[15:12];
    assign ofs        = addr_i[11:0];

    // ack low means this is the first cycle of the transfer
    assign wr_first = sel_i && we_i && region_hit && !ack_o;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            ack_o <= 1'b0;
        end else begin
            ack_o <= sel_i && region_hit;
        end
    end

    always_comb begin
        tmr_ena_we_o  = wr_first && (page == dev_map_pkg::PAGE_SYS)
                        && (ofs == dev_map_pkg::OFS_CTRL);
        // display register answers on the whole page
        disp_we_o     = wr_first && (page == dev_map_pkg::PAGE_DISPLAY);
        sd_we_o       = wr_first && (page == dev_map_pkg::PAGE_SD)
                        && (ofs == dev_map_pkg::OFS_CTRL);
        // no dequeue request on an empty queue
        kbd_deq_req_o = wr_first && (page == dev_map_pkg::PAGE_KBD)
                        && (ofs == dev_map_pkg::OFS_KBD_STATUS) && kbd_nonempty_i;
    end

    // read mux, zero extended; unmapped offsets read zero
    always_comb begin
        rdata_o = '0;
        if (region_hit) begin
            case (page)
                dev_map_pkg::PAGE_SYS: begin
                    if (ofs == dev_map_pkg::OFS_CTRL)
                        rdata_o[0] = tmr_ena_i;
                end
                dev_map_pkg::PAGE_DISPLAY: begin
                    rdata_o[soc_bus_pkg::BYTE_W-1:0] = disp_i;
                end
                dev_map_pkg::PAGE_KBD: begin
                    if (ofs == dev_map_pkg::OFS_KBD_STATUS)
                        rdata_o[0] = kbd_nonempty_i;
                    else if (ofs == dev_map_pkg::OFS_KBD_CODE)
                        rdata_o[soc_bus_pkg::BYTE_W-1:0] = kbd_code_i;
                end
                dev_map_pkg::PAGE_SD: begin
                    if (ofs == dev_map_pkg::OFS_CTRL)
                        rdata_o[0] = sd_miso_i;
                end
                default: begin
                    rdata_o = '0;
                end
            endcase
        end
    end

endmodule

// File: hw/dev_map_pkg.sv
/*
  device region memory map, 0x2000_0000 to 0x2FFF_FFFF
  page is addr[15:12], register offset is addr[11:0]
*/
package dev_map_pkg;

    // top address nibble of the device region
    localparam logic [3:0] REGION_DEV = 4'h2;

    // device pages
    localparam logic [3:0] PAGE_SYS     = 4'h0;
    localparam logic [3:0] PAGE_DISPLAY = 4'h1;
    localparam logic [3:0] PAGE_KBD     = 4'h5;
    localparam logic [3:0] PAGE_SD      = 4'h6;

    // keyboard page offsets
    //   status: bit 0 nonempty, write dequeues
    //   code: last dequeued code
    localparam logic [11:0] OFS_KBD_STATUS = 12'd0;
    localparam logic [11:0] OFS_KBD_CODE   = 12'd4;

    // single register of the system and sd pages
    localparam logic [11:0] OFS_CTRL = 12'd0;

    // sd control word, write side
    // read side returns miso in bit 0
    localparam int SD_BIT_MOSI = 0;
    localparam int SD_BIT_CS   = 1;
    localparam int SD_BIT_SCLK = 2;

endpackage

// File: hw/soc_bus_pkg.sv
/*
  bus word widths shared by all device RTL
  byte_t carries both the display byte and the keyboard code
*/
package soc_bus_pkg;

    // cpu bus
    localparam int ADDR_W = 32;
    localparam int DATA_W = 32;

    // display byte and keyboard scan code
    localparam int BYTE_W = 8;

    typedef logic [ADDR_W-1:0] addr_t;

    typedef logic [DATA_W-1:0] data_t;

    typedef logic [BYTE_W-1:0] byte_t;

endpackage
